/* rv_core.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/bus_pkg.sv
hdl/fetch_unit.sv
hdl/inst_queue.sv
hdl/exec_unit.sv
hdl/rv_core.sv
testbench/tb_rv_core.sv

/* Makefile */
TOP = tb_rv_core
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f rv_core.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Testbench passed" $(LOG)

lint:
	verilator --lint-only --timing --assert -f rv_core.f --top-module rv_core

clean:
	rm -rf obj_dir $(LOG)

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module tb_rv_core;
	import isa_pkg::*;
	import bus_pkg::*;

	localparam int          N               = 40;  // Legal instructions per program.
	localparam int          RESET_CYCLES    = 10;
	localparam int          DRIVE_DELAY     = 5;
	localparam int          WATCHDOG_CYCLES = N * 20;
	localparam logic [31:0] ILLEGAL_WORD    = 32'hffff_ffff;

	typedef enum int {
		K_LUI, K_ADDI, K_SLTI, K_XORI, K_ORI, K_ANDI,
		K_ADD, K_SUB, K_SLT, K_XOR, K_OR, K_AND
	} inst_kind_e;

	logic        clock;
	logic        arst_n;
	logic        arvalid;
	logic [31:0] araddr;
	logic        arready;
	logic        rvalid;
	logic [31:0] rdata;
	resp_e       rresp;
	logic        rready;
	logic        retire_valid;
	logic [3:0]  retire_rd;
	logic [31:0] retire_data;
	logic        fault;

	inst_kind_e  p_kind [N];
	logic [3:0]  p_rd   [N];
	logic [3:0]  p_rs1  [N];
	logic [3:0]  p_rs2  [N];
	logic [31:0] p_imm  [N];  // Already sign extended, or upper bits for LUI.
	logic [31:0] prog   [N+1];
	logic [31:0] model_regs [`REG_COUNT];
	int          retired;
	int          expect_retires;
	logic        inject_err;
	logic [31:0] err_addr;
	int          err_index;

	rv_core dut (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t: %s", $time, msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Program and reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] encode(input int i);
		logic [2:0] f3;
		logic       sub;
		case (p_kind[i])
			K_ADDI, K_ADD, K_SUB: f3 = 3'b000;
			K_SLTI, K_SLT:        f3 = 3'b010;
			K_XORI, K_XOR:        f3 = 3'b100;
			K_ORI, K_OR:          f3 = 3'b110;
			default:              f3 = 3'b111;
		endcase
		sub = (p_kind[i] == K_SUB);
		case (p_kind[i])
			K_LUI: return {p_imm[i][31:12], 1'b0, p_rd[i], OPC_LUI};
			K_ADDI, K_SLTI, K_XORI, K_ORI, K_ANDI:
				return {p_imm[i][11:0], 1'b0, p_rs1[i], f3, 1'b0, p_rd[i], OPC_OP_IMM};
			default:
				return {1'b0, sub, 5'b0, 1'b0, p_rs2[i], 1'b0, p_rs1[i], f3,
					1'b0, p_rd[i], OPC_OP};
		endcase
	endfunction

	function automatic logic [31:0] ref_result(input int i);
		logic [31:0] a;
		logic [31:0] b;
		a = model_regs[p_rs1[i]];
		case (p_kind[i])
			K_ADD, K_SUB, K_SLT, K_XOR, K_OR, K_AND: b = model_regs[p_rs2[i]];
			default: b = p_imm[i];
		endcase
		if (p_rd[i] == 4'd0)
			return '0;  // Writes to x0 retire as zero.
		case (p_kind[i])
			K_LUI:         return p_imm[i];
			K_ADDI, K_ADD: return a + b;
			K_SUB:         return a - b;
			K_SLTI, K_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			K_XORI, K_XOR: return a ^ b;
			K_ORI, K_OR:   return a | b;
			default:       return a & b;
		endcase
	endfunction

	task automatic build_program();
		logic [31:0] raw;
		for (int i = 0; i < N; i++) begin
			p_kind[i] = inst_kind_e'($urandom % 12);
			p_rd[i]   = (i % 7 == 3) ? 4'd0 : 4'($urandom % 16);
			p_rs1[i]  = (i % 7 == 4) ? 4'd0 : 4'($urandom % 16);  // Reads x0 after its write.
			p_rs2[i]  = 4'($urandom % 16);
			raw       = $urandom;
			if (p_kind[i] == K_LUI)
				p_imm[i] = {raw[31:12], 12'b0};
			else
				p_imm[i] = {{20{raw[11]}}, raw[11:0]};
			prog[i] = encode(i);
		end
		prog[N] = ILLEGAL_WORD;
	endtask

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - `RESET_PC;
		if (offset < 32'(4 * (N + 1)))
			return prog[offset[31:2]];
		return ~addr;  // Past the program.
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Instruction memory
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		logic        in_reset;
		logic        ar_hs;
		logic        r_hs;
		logic        pending;
		logic [31:0] pend_addr;
		logic [31:0] next_addr;
		arready   = 1'b0;
		rvalid    = 1'b0;
		rdata     = '0;
		rresp     = RESP_OKAY;
		pending   = 1'b0;
		pend_addr = '0;
		next_addr = `RESET_PC;
		forever begin
			@(negedge clock);
			in_reset = !arst_n;
			ar_hs    = !in_reset && arvalid && arready;
			r_hs     = !in_reset && rvalid && rready;
			if (in_reset) begin
				next_addr = `RESET_PC;
			end else begin
				if (arvalid)
					assert (araddr == next_addr) else report_mismatch($sformatf(
						"araddr 0x%08h, expected 0x%08h", araddr, next_addr));
				// rready only while a read is in flight.
				assert (rready == (pending || rvalid)) else report_mismatch($sformatf(
					"rready %0b, expected %0b", rready, pending || rvalid));
			end
			@(posedge clock);
			#(DRIVE_DELAY);
			if (in_reset) begin
				arready = 1'b0;
				rvalid  = 1'b0;
				pending = 1'b0;
			end else begin
				if (ar_hs) begin
					assert (!pending && !rvalid)
						else report_error("second read issued while one was in flight");
					pending   = 1'b1;
					pend_addr = next_addr;
					next_addr = next_addr + 32'd4;
				end
				if (r_hs)
					rvalid = 1'b0;
				if (pending && !rvalid && ($urandom % 3) != 0) begin
					rvalid  = 1'b1;
					rdata   = mem_word(pend_addr);
					rresp   = (inject_err && pend_addr == err_addr) ? RESP_SLVERR : RESP_OKAY;
					pending = 1'b0;
				end
				arready = ($urandom % 4) != 0;  // Random AR stalls.
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clock) begin
		logic [31:0] exp_data;
		if (!arst_n) begin
			assert (!retire_valid && !fault && !arvalid)
				else report_error("retire, fault or arvalid active during reset");
			for (int r = 0; r < `REG_COUNT; r++)
				model_regs[r] = '0;
			retired = 0;
		end else if (retire_valid) begin
			assert (retired < expect_retires)
				else report_error("retire seen after the last expected instruction");
			exp_data = ref_result(retired);
			assert (retire_rd == p_rd[retired]) else report_mismatch($sformatf(
				"retire %0d rd x%0d, expected x%0d", retired, retire_rd, p_rd[retired]));
			assert (retire_data == exp_data) else report_mismatch($sformatf(
				"retire %0d data 0x%08h, expected 0x%08h", retired, retire_data, exp_data));
			if (p_rd[retired] != 4'd0)
				model_regs[p_rd[retired]] = exp_data;
			retired = retired + 1;
		end
	end

	ar_hold: assert property (
		@(posedge clock) disable iff (!arst_n)
		arvalid && !arready |=> arvalid && $stable(araddr)
	) else report_mismatch("araddr or arvalid changed while the address waited");

	quiet_after_fault: assert property (
		@(posedge clock) disable iff (!arst_n)
		fault |-> !retire_valid
	) else report_error("retire_valid high while fault is set");

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		report_error($sformatf("timeout after %0d cycles", WATCHDOG_CYCLES));
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic run_segment(input int count, input logic with_err, input int err_idx);
		expect_retires = count;
		inject_err     = with_err;
		err_addr       = `RESET_PC + 32'(4 * err_idx);
		@(posedge clock);
		#(DRIVE_DELAY);
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#(DRIVE_DELAY);
		arst_n = 1'b1;
		wait (fault);
		repeat (8) @(posedge clock);  // Room for a stray retire.
		assert (retired == count) else report_mismatch($sformatf(
			"%0d retires before fault, expected %0d", retired, count));
	endtask

	initial begin
		arst_n         = 1'b0;
		expect_retires = 0;
		inject_err     = 1'b0;
		err_addr       = '0;
		void'($urandom(32'he33c));
		build_program();
		run_segment(N, 1'b0, 0);  // Ends on the illegal word.
		err_index = 1 + int'($urandom % (N - 1));
		run_segment(err_index, 1'b1, err_index);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
	input  logic           clock,
	input  logic           arst_n,
	output logic           arvalid,
	output logic [31:0]    araddr,
	input  logic           arready,
	input  logic           rvalid,
	input  logic [31:0]    rdata,
	input  bus_pkg::resp_e rresp,
	output logic           rready,
	output logic           retire_valid,
	output logic [3:0]     retire_rd,
	output logic [31:0]    retire_data,
	output logic           fault
);
	logic        push_valid;
	logic [31:0] push_inst;
	logic        push_err;
	logic        push_ready;
	logic        pop_valid;
	logic [31:0] pop_inst;
	logic        pop_err;
	logic        pop_ready;

	fetch_unit u_fetch (
		.clock      (clock),
		.arst_n     (arst_n),
		.arvalid    (arvalid),
		.araddr     (araddr),
		.rready     (rready),
		.arready    (arready),
		.rvalid     (rvalid),
		.rdata      (rdata),
		.rresp      (rresp),
		.push_valid (push_valid),
		.push_inst  (push_inst),
		.push_err   (push_err),
		.push_ready (push_ready)
	);

	inst_queue u_queue (
		.clock      (clock),
		.arst_n     (arst_n),
		.push_valid (push_valid),
		.push_inst  (push_inst),
		.push_err   (push_err),
		.push_ready (push_ready),
		.pop_valid  (pop_valid),
		.pop_inst   (pop_inst),
		.pop_err    (pop_err),
		.pop_ready  (pop_ready)
	);

	exec_unit u_exec (
		.clock        (clock),
		.arst_n       (arst_n),
		.pop_valid    (pop_valid),
		.pop_inst     (pop_inst),
		.pop_err      (pop_err),
		.pop_ready    (pop_ready),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data),
		.fault        (fault)
	);

endmodule

`default_nettype wire

/* hdl/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module exec_unit (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        pop_valid,
	input  logic [31:0] pop_inst,
	input  logic        pop_err,
	output logic        pop_ready,
	output logic        retire_valid,
	output logic [3:0]  retire_rd,
	output logic [31:0] retire_data,
	output logic        fault
);
	import isa_pkg::*;

	localparam int REGS = `REG_COUNT;

	logic [31:0] regs [REGS];
	opcode_e     opcode;
	alu_op_e     alu_op;
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [2:0]  funct3;
	logic        funct7_5;
	logic [5:0]  funct7_rest;
	logic [31:0] imm_i;
	logic [31:0] imm_u;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] alu_res;
	logic [31:0] result;
	logic        legal;
	logic        inst_ok;
	logic        fire;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign opcode      = opcode_e'(pop_inst[6:0]);
	assign rd          = pop_inst[11:7];
	assign funct3      = pop_inst[14:12];
	assign rs1         = pop_inst[19:15];
	assign rs2         = pop_inst[24:20];
	assign funct7_5    = pop_inst[30];
	assign funct7_rest = {pop_inst[31], pop_inst[29:25]};
	assign imm_i       = {{20{pop_inst[31]}}, pop_inst[31:20]};
	assign imm_u       = {pop_inst[31:12], 12'b0};

	always_comb begin
		alu_op = ALU_ADD;
		legal  = 1'b0;
		case (opcode)
			OPC_LUI: legal = ~rd[4];
			OPC_OP_IMM, OPC_OP: begin
				legal = ~rd[4] & ~rs1[4];
				case (funct3)
					3'b000: alu_op = (opcode == OPC_OP && funct7_5) ? ALU_SUB : ALU_ADD;
					3'b010: alu_op = ALU_SLT;
					3'b100: alu_op = ALU_XOR;
					3'b110: alu_op = ALU_OR;
					3'b111: alu_op = ALU_AND;
					default: legal = 1'b0;
				endcase
				// Register form, funct7 is zero except bit 5 on SUB.
				if (opcode == OPC_OP)
					legal = legal & ~rs2[4] & (funct7_rest == '0) &
						(~funct7_5 | (funct3 == 3'b000));
			end
			default: legal = 1'b0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Execute
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign op_a = regs[rs1[3:0]];
	assign op_b = (opcode == OPC_OP) ? regs[rs2[3:0]] : imm_i;

	always_comb begin
		case (alu_op)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_XOR: alu_res = op_a ^ op_b;
			ALU_OR:  alu_res = op_a | op_b;
			ALU_AND: alu_res = op_a & op_b;
			default: alu_res = '0;
		endcase
	end

	assign result    = (opcode == OPC_LUI) ? imm_u : alu_res;
	assign inst_ok   = legal & ~pop_err;
	assign pop_ready = ~fault;  // Core stops for good on a fault.
	assign fire      = pop_valid & pop_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Writeback and retire
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < REGS; i++)
				regs[i] <= '0;
			retire_valid <= 1'b0;
			fault        <= 1'b0;
		end else begin
			retire_valid <= fire && inst_ok;
			if (fire && inst_ok && rd[3:0] != 4'd0)
				regs[rd[3:0]] <= result;  // x0 stays zero.
			if (fire && !inst_ok)
				fault <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (fire && inst_ok) begin
			retire_rd   <= rd[3:0];
			retire_data <= (rd[3:0] == 4'd0) ? '0 : result;
		end
	end

	no_retire_after_fault: assert property (
		@(posedge clock) disable iff (!arst_n)
		fault |=> !retire_valid
	);

endmodule

`default_nettype wire

/* hdl/inst_queue.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module inst_queue (
	input  logic        clock,
	input  logic        arst_n,
	input  logic        push_valid,
	input  logic [31:0] push_inst,
	input  logic        push_err,
	output logic        push_ready,
	output logic        pop_valid,
	output logic [31:0] pop_inst,
	output logic        pop_err,
	input  logic        pop_ready
);
	localparam int DEPTH = `QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [31:0]      inst_mem [DEPTH];
	logic             err_mem  [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign push_ready = (count != CNT_W'(DEPTH));
	assign pop_valid  = (count != '0);
	assign do_push    = push_valid && push_ready;
	assign do_pop     = pop_valid && pop_ready;
	assign pop_inst   = inst_mem[rd_ptr];
	assign pop_err    = err_mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			inst_mem[wr_ptr] <= push_inst;
			err_mem[wr_ptr]  <= push_err;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	occupancy_bound: assert property (
		@(posedge clock) disable iff (!arst_n)
		count <= CNT_W'(DEPTH)
	);

endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module fetch_unit (
	input  logic           clock,
	input  logic           arst_n,
	output logic           arvalid,
	output logic [31:0]    araddr,
	output logic           rready,
	input  logic           arready,
	input  logic           rvalid,
	input  logic [31:0]    rdata,
	input  bus_pkg::resp_e rresp,
	output logic           push_valid,
	output logic [31:0]    push_inst,
	output logic           push_err,
	input  logic           push_ready
);
	import bus_pkg::*;

	fetch_state_e state;
	fetch_state_e state_next;
	logic [31:0]  pc;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fetch FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		state_next = state;
		case (state)
			FETCH_IDLE: state_next = FETCH_ADDR;
			FETCH_ADDR: begin
				if (arready)
					state_next = FETCH_DATA;
			end
			FETCH_DATA: begin
				if (rvalid)
					state_next = FETCH_PUSH;
			end
			FETCH_PUSH: begin
				if (push_ready)
					state_next = FETCH_ADDR;  // Next word only after the queue took this one.
			end
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= FETCH_IDLE;
			pc    <= `RESET_PC;
		end else begin
			state <= state_next;
			if (arvalid && arready)
				pc <= pc + 32'd4;  // Sequential fetch only.
		end
	end

	// Captured read word and its response.
	always_ff @(posedge clock) begin
		if (rvalid && rready) begin
			push_inst <= rdata;
			push_err  <= (rresp != RESP_OKAY);
		end
	end

	assign arvalid    = (state == FETCH_ADDR);
	assign araddr     = pc;
	assign rready     = (state == FETCH_DATA);  // Full queue backs up onto the bus.
	assign push_valid = (state == FETCH_PUSH);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A pending read address holds until the slave takes it.
	ar_stable: assert property (
		@(posedge clock) disable iff (!arst_n)
		arvalid && !arready |=> arvalid && $stable(araddr)
	);

endmodule

`default_nettype wire

/* hdl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

	typedef enum logic [1:0] {
		FETCH_IDLE = 2'd0,  // Only after reset.
		FETCH_ADDR = 2'd1,  // AR channel request.
		FETCH_DATA = 2'd2,  // Waiting on R channel.
		FETCH_PUSH = 2'd3   // Word held for the queue.
	} fetch_state_e;

endpackage

`default_nettype wire

/* hdl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Major opcodes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,  // Load upper immediate.
		OPC_OP_IMM = 7'b0010011,  // Register-immediate ALU.
		OPC_OP     = 7'b0110011   // Register-register ALU.
	} opcode_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU operations
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_SLT = 3'd2,  // Signed compare.
		ALU_XOR = 3'd3,
		ALU_OR  = 3'd4,
		ALU_AND = 3'd5
	} alu_op_e;

endpackage

`default_nettype wire

/* hdl/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core configuration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Address of the first instruction fetch.
`define RESET_PC 32'h8000_0000

// Entries in the fetch-to-execute instruction queue.
`define QUEUE_DEPTH 4

// Architectural registers of RV32E.
`define REG_COUNT 16

`endif
